// ==== hw/fw_ctrl_defs.svh ====
/*
 * Firmware control block definitions
 * Register map, identity words, memory map limits and field widths
 * shared by the control block RTL and its testbench.
 */

`ifndef FW_CTRL_DEFS_SVH
`define FW_CTRL_DEFS_SVH

// ---------------------------------------------------------------------------
// Register addresses
// ---------------------------------------------------------------------------
`define FW_ADDR_NAME0        8'h00
`define FW_ADDR_NAME1        8'h01
`define FW_ADDR_VERSION      8'h02
`define FW_ADDR_SYSTEM_MODE  8'h08
`define FW_ADDR_LED          8'h09
`define FW_ADDR_GPIO         8'h0a
`define FW_ADDR_APP_START    8'h0c
`define FW_ADDR_APP_SIZE     8'h0d
`define FW_ADDR_SYSCALL      8'h12
`define FW_ADDR_CDI_FIRST    8'h20
`define FW_ADDR_CDI_LAST     8'h27
`define FW_ADDR_MON_CTRL     8'h60
`define FW_ADDR_MON_FIRST    8'h61
`define FW_ADDR_MON_LAST     8'h62
`define FW_ADDR_SYSTEM_RESET 8'h70

// Identity words, "tk1 " and "mkdf" in ASCII
`define FW_NAME0             32'h746b3120
`define FW_NAME1             32'h6d6b6466
`define FW_VERSION           32'h00000005

// ---------------------------------------------------------------------------
// Memory map limits
// ---------------------------------------------------------------------------
`define FW_RAM_FIRST         32'hd0000000
`define FW_RAM_LAST          32'hd00007ff
`define FW_ROM_LAST          32'h00001fff
// Outside physical memory, so a call here traps
`define FW_ILLEGAL_ADDR      32'h4f000000

// Field widths and reset values
`define FW_DATA_W            32
`define FW_ADDR_W            8
`define FW_CDI_WORDS         8
`define FW_LED_RESET         3'h6

`endif

// ==== hw/fw_ctrl_pkg.sv ====
/*
 * Firmware control package
 * Packed bus and CPU fetch types shared by the control block modules.
 */

`default_nettype none

`include "fw_ctrl_defs.svh"

package fw_ctrl_pkg;

  // Host bus request, sampled with ready in the same cycle
  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [`FW_ADDR_W-1:0] address;
    logic [`FW_DATA_W-1:0] write_data;
  } bus_req_t;

  // Bus response, read data valid while cs is high
  typedef struct packed {
    logic [`FW_DATA_W-1:0] read_data;
    logic                  ready;
  } bus_rsp_t;

  // Observed CPU memory access
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
  } cpu_fetch_t;

endpackage

`default_nettype wire

// ==== hw/mode_ctrl.sv ====
/*
 * System mode controller
 * Tracks the privilege level from observed instruction fetches.
 * Fetching from the syscall entry lowers the mode, fetching above
 * the ROM raises it again.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fw_ctrl_defs.svh"

module mode_ctrl (
  input  logic                   clk,
  input  logic                   reset_n,
  input  fw_ctrl_pkg::cpu_fetch_t cpu,
  input  logic [31:0]            syscall_addr,
  output logic                   system_mode
);

  logic instr_fetch;
  logic enter_app;
  logic enter_syscall;

  assign instr_fetch   = cpu.valid && cpu.instr;
  assign enter_app     = instr_fetch && (cpu.addr > `FW_ROM_LAST);
  assign enter_syscall = instr_fetch && (cpu.addr == syscall_addr);

  // Setting has priority over clearing
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode <= 1'b0;
    end else if (enter_app) begin
      system_mode <= 1'b1;
    end else if (enter_syscall) begin
      system_mode <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/exec_monitor.sv ====
/*
 * Execution monitor and security trap
 * Holds the execution-monitor window, which locks once enabled, and
 * raises a sticky force_trap on out-of-range RAM accesses, fetches
 * from firmware RAM and fetches inside the enabled window.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fw_ctrl_defs.svh"

module exec_monitor (
  input  logic                   clk,
  input  logic                   reset_n,
  input  fw_ctrl_pkg::bus_req_t   bus_req,
  input  fw_ctrl_pkg::cpu_fetch_t cpu,
  output logic                   force_trap
);

  logic        bus_write;
  logic        mon_en;
  logic [31:0] mon_first;
  logic [31:0] mon_last;
  logic        ram_out_of_range;
  logic        fw_ram_fetch;
  logic        window_fetch;
  logic        trap_set;

  assign bus_write = bus_req.cs && bus_req.we;

  // ---------------------------------------------------------------------------
  // Window registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mon_en    <= 1'b0;
      mon_first <= 32'h0;
      mon_last  <= 32'h0;
    end else if (bus_write) begin
      // Enable is one way until reset
      if (bus_req.address == `FW_ADDR_MON_CTRL) begin
        mon_en <= 1'b1;
      end
      if ((bus_req.address == `FW_ADDR_MON_FIRST) && !mon_en) begin
        mon_first <= bus_req.write_data;
      end
      if ((bus_req.address == `FW_ADDR_MON_LAST) && !mon_en) begin
        mon_last <= bus_req.write_data;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Violation detection
  // ---------------------------------------------------------------------------
  // RAM region beyond the physical memory size
  assign ram_out_of_range = (cpu.addr[31:30] == 2'b01) && (|cpu.addr[29:17]);

  assign fw_ram_fetch = cpu.instr && (cpu.addr >= `FW_RAM_FIRST) &&
                        (cpu.addr <= `FW_RAM_LAST);

  // Bounds are inclusive
  assign window_fetch = cpu.instr && mon_en && (cpu.addr >= mon_first) &&
                        (cpu.addr <= mon_last);

  assign trap_set = cpu.valid && (ram_out_of_range || fw_ram_fetch || window_fetch);

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (trap_set) begin
      force_trap <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ctrl_regs.sv ====
/*
 * Firmware control register bank
 * Memory-mapped identity, LED, GPIO, application and syscall
 * registers plus the CDI store. Privileged registers are write
 * protected in system mode. Also generates the system reset strobe.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fw_ctrl_defs.svh"

module ctrl_regs #(
  parameter logic [31:0] app_size_reset = 32'h0
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fw_ctrl_pkg::bus_req_t bus_req,
  output fw_ctrl_pkg::bus_rsp_t bus_rsp,
  input  logic                 system_mode,
  output logic [31:0]          syscall_addr,
  input  logic                 gpio1,
  input  logic                 gpio2,
  output logic                 gpio3,
  output logic                 gpio4,
  output logic                 led_r,
  output logic                 led_g,
  output logic                 led_b,
  output logic                 system_reset
);

  logic                  bus_write;
  logic                  bus_read;
  logic                  cdi_hit;
  logic [2:0]            cdi_idx;
  logic                  priv_ok;

  logic [2:0]            led_q;
  logic [1:0]            gpio1_sync;
  logic [1:0]            gpio2_sync;
  logic [31:0]           app_start_q;
  logic [31:0]           app_size_q;
  logic [`FW_DATA_W-1:0] cdi_mem [`FW_CDI_WORDS];
  logic [`FW_DATA_W-1:0] rd_data;

  assign bus_write = bus_req.cs && bus_req.we;
  assign bus_read  = bus_req.cs && !bus_req.we;
  assign cdi_hit   = (bus_req.address >= `FW_ADDR_CDI_FIRST) &&
                     (bus_req.address <= `FW_ADDR_CDI_LAST);
  assign cdi_idx   = bus_req.address[2:0];

  // Privileged registers only writable outside system mode
  assign priv_ok = !system_mode;

  // ---------------------------------------------------------------------------
  // Register updates
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_q        <= `FW_LED_RESET;
      gpio3        <= 1'b0;
      gpio4        <= 1'b0;
      app_start_q  <= 32'h0;
      app_size_q   <= app_size_reset;
      syscall_addr <= `FW_ILLEGAL_ADDR;
      system_reset <= 1'b0;
      for (int i = 0; i < `FW_CDI_WORDS; i++) begin
        cdi_mem[i] <= '0;
      end
    end else begin
      // One-cycle strobe
      system_reset <= bus_write && (bus_req.address == `FW_ADDR_SYSTEM_RESET);

      if (bus_write) begin
        if (bus_req.address == `FW_ADDR_LED) begin
          led_q <= bus_req.write_data[2:0];
        end
        if (bus_req.address == `FW_ADDR_GPIO) begin
          gpio3 <= bus_req.write_data[2];
          gpio4 <= bus_req.write_data[3];
        end
        if (priv_ok && (bus_req.address == `FW_ADDR_APP_START)) begin
          app_start_q <= bus_req.write_data;
        end
        if (priv_ok && (bus_req.address == `FW_ADDR_APP_SIZE)) begin
          app_size_q <= bus_req.write_data;
        end
        if (priv_ok && (bus_req.address == `FW_ADDR_SYSCALL)) begin
          syscall_addr <= bus_req.write_data;
        end
        if (priv_ok && cdi_hit) begin
          cdi_mem[cdi_idx] <= bus_req.write_data;
        end
      end
    end
  end

  // Two-stage input synchronizers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gpio1_sync <= 2'b00;
      gpio2_sync <= 2'b00;
    end else begin
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};
    end
  end

  // ---------------------------------------------------------------------------
  // Readback
  // ---------------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (bus_read) begin
      case (bus_req.address)
        `FW_ADDR_NAME0:       rd_data = `FW_NAME0;
        `FW_ADDR_NAME1:       rd_data = `FW_NAME1;
        `FW_ADDR_VERSION:     rd_data = `FW_VERSION;
        `FW_ADDR_SYSTEM_MODE: rd_data = {32{system_mode}};
        `FW_ADDR_LED:         rd_data = {29'h0, led_q};
        `FW_ADDR_GPIO:        rd_data = {28'h0, gpio4, gpio3, gpio2_sync[1], gpio1_sync[1]};
        `FW_ADDR_APP_START:   rd_data = app_start_q;
        `FW_ADDR_APP_SIZE:    rd_data = app_size_q;
        `FW_ADDR_SYSCALL:     rd_data = syscall_addr;
        default: begin
          if (cdi_hit) begin
            rd_data = cdi_mem[cdi_idx];
          end
        end
      endcase
    end
  end

  // No wait states
  assign bus_rsp = '{read_data: rd_data, ready: bus_req.cs};

  // LED bits r, g, b from high to low
  assign led_r = led_q[2];
  assign led_g = led_q[1];
  assign led_b = led_q[0];

endmodule

`default_nettype wire

// ==== hw/fw_ctrl_top.sv ====
/*
 * Firmware control block top level
 * Connects the register bank, the system mode controller and the
 * execution monitor to the host bus and the pins.
 */

`timescale 1ns/1ps
`default_nettype none

module fw_ctrl_top #(
  parameter logic [31:0] app_size_reset = 32'h0
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  fw_ctrl_pkg::bus_req_t   bus_req,
  output fw_ctrl_pkg::bus_rsp_t   bus_rsp,
  input  fw_ctrl_pkg::cpu_fetch_t cpu,
  output logic                   force_trap,
  output logic                   system_mode,
  output logic                   system_reset,
  output logic                   led_r,
  output logic                   led_g,
  output logic                   led_b,
  input  logic                   gpio1,
  input  logic                   gpio2,
  output logic                   gpio3,
  output logic                   gpio4
);

  logic [31:0] syscall_addr;

  mode_ctrl mode_ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .cpu          (cpu),
    .syscall_addr (syscall_addr),
    .system_mode  (system_mode)
  );

  exec_monitor exec_monitor_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .bus_req    (bus_req),
    .cpu        (cpu),
    .force_trap (force_trap)
  );

  ctrl_regs #(
    .app_size_reset (app_size_reset)
  ) ctrl_regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp),
    .system_mode  (system_mode),
    .syscall_addr (syscall_addr),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .gpio3        (gpio3),
    .gpio4        (gpio4),
    .led_r        (led_r),
    .led_g        (led_g),
    .led_b        (led_b),
    .system_reset (system_reset)
  );

endmodule

`default_nettype wire

// ==== dv/fw_ctrl_chk.sv ====
/*
 * Firmware control block assertions
 * Bus handshake, sticky trap, system reset strobe width and the
 * output state after reset. Bound into fw_ctrl_top.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fw_ctrl_defs.svh"

module fw_ctrl_chk (
  input logic                  clk,
  input logic                  reset_n,
  input fw_ctrl_pkg::bus_req_t bus_req,
  input fw_ctrl_pkg::bus_rsp_t bus_rsp,
  input logic                  force_trap,
  input logic                  system_mode,
  input logic                  system_reset,
  input logic                  led_r,
  input logic                  led_g,
  input logic                  led_b,
  input logic                  gpio3,
  input logic                  gpio4
);

  logic reset_write;

  assign reset_write = bus_req.cs && bus_req.we &&
                       (bus_req.address == `FW_ADDR_SYSTEM_RESET);

  ready_is_cs: assert property (@(posedge clk) bus_rsp.ready == bus_req.cs)
    else $error("bus ready differs from cs");

  // Only reset may clear the trap
  trap_sticky: assert property (@(posedge clk) (reset_n && force_trap) |=> force_trap)
    else $error("force_trap fell while out of reset");

  strobe_single: assert property (@(posedge clk) disable iff (!reset_n)
                                  (system_reset && !reset_write) |=> !system_reset)
    else $error("system_reset high for more than one cycle");

  strobe_cause: assert property (@(posedge clk) disable iff (!reset_n)
                                 system_reset |-> $past(reset_write))
    else $error("system_reset without a preceding reset write");

  reset_outputs: assert property (@(posedge clk) !reset_n |=>
                                  (!system_mode && !force_trap && !system_reset &&
                                   !gpio3 && !gpio4 && led_r && led_g && !led_b))
    else $error("outputs not in their reset state");

endmodule

bind fw_ctrl_top fw_ctrl_chk fw_ctrl_chk_i (
  .clk          (clk),
  .reset_n      (reset_n),
  .bus_req      (bus_req),
  .bus_rsp      (bus_rsp),
  .force_trap   (force_trap),
  .system_mode  (system_mode),
  .system_reset (system_reset),
  .led_r        (led_r),
  .led_g        (led_g),
  .led_b        (led_b),
  .gpio3        (gpio3),
  .gpio4        (gpio4)
);

`default_nettype wire

// ==== dv/fw_ctrl_tb.sv ====
/*
 * Firmware control block testbench
 * Drives register traffic, GPIO inputs, CPU fetches and monitor
 * programming into fw_ctrl_top and compares every response with a
 * reference model of the register map, the system mode and the trap.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fw_ctrl_defs.svh"

module fw_ctrl_tb;

  localparam logic [31:0] APP_SIZE_RESET = 32'h0001_2a40;
  localparam logic [31:0] SEED           = 32'h4c377cab;
  localparam int          RESET_CYCLES   = 16;
  localparam int          RAND_OPS       = 200;
  localparam int          GPIO_ROUNDS    = 16;
  localparam int          LEGAL_ROUNDS   = 40;
  // Nine resets plus the body of each test
  localparam int PLANNED_CYCLES = 9 * (RESET_CYCLES + 1) + 48 + (RAND_OPS + 1) +
                                  4 * GPIO_ROUNDS + 16 + 20 + LEGAL_ROUNDS + 8;
  localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

  logic                    clk;
  logic                    reset_n;
  fw_ctrl_pkg::bus_req_t   bus_req;
  fw_ctrl_pkg::bus_rsp_t   bus_rsp;
  fw_ctrl_pkg::cpu_fetch_t cpu;
  logic                    force_trap;
  logic                    system_mode;
  logic                    system_reset;
  logic                    led_r;
  logic                    led_g;
  logic                    led_b;
  logic                    gpio1;
  logic                    gpio2;
  logic                    gpio3;
  logic                    gpio4;

  // Reference model state
  logic [31:0] model_reg [256];
  logic        model_mode;
  logic        model_trap;
  logic        model_mon_en;
  logic [31:0] model_mon_first;
  logic [31:0] model_mon_last;
  logic [1:0]  model_gpio_out;
  logic [1:0]  model_gpio_in;

  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          tests_run;
  int          cycle_count = 0;

  fw_ctrl_top #(.app_size_reset(APP_SIZE_RESET)) fw_ctrl_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: no end of test after %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] random_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ---------------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------------
  task automatic check_rsp(input string name, input fw_ctrl_pkg::bus_rsp_t got,
                           input fw_ctrl_pkg::bus_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got data %h ready %b, expected data %h ready %b",
               $time, name, got.read_data, got.ready, exp.read_data, exp.ready);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic void reset_model();
    for (int i = 0; i < 256; i++) begin
      model_reg[i] = 32'h0;
    end
    model_reg[`FW_ADDR_NAME0]    = `FW_NAME0;
    model_reg[`FW_ADDR_NAME1]    = `FW_NAME1;
    model_reg[`FW_ADDR_VERSION]  = `FW_VERSION;
    model_reg[`FW_ADDR_LED]      = {29'h0, `FW_LED_RESET};
    model_reg[`FW_ADDR_APP_SIZE] = APP_SIZE_RESET;
    model_reg[`FW_ADDR_SYSCALL]  = `FW_ILLEGAL_ADDR;
    model_mode      = 1'b0;
    model_trap      = 1'b0;
    model_mon_en    = 1'b0;
    model_mon_first = 32'h0;
    model_mon_last  = 32'h0;
    model_gpio_out  = 2'b00;
  endfunction

  function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
    logic privileged;
    privileged = (addr == `FW_ADDR_APP_START) || (addr == `FW_ADDR_APP_SIZE) ||
                 (addr == `FW_ADDR_SYSCALL) ||
                 ((addr >= `FW_ADDR_CDI_FIRST) && (addr <= `FW_ADDR_CDI_LAST));
    if (addr == `FW_ADDR_LED) begin
      model_reg[addr] = {29'h0, data[2:0]};
    end else if (addr == `FW_ADDR_GPIO) begin
      model_gpio_out = data[3:2];
    end else if (addr == `FW_ADDR_MON_CTRL) begin
      model_mon_en = 1'b1;
    end else if ((addr == `FW_ADDR_MON_FIRST) && !model_mon_en) begin
      model_mon_first = data;
    end else if ((addr == `FW_ADDR_MON_LAST) && !model_mon_en) begin
      model_mon_last = data;
    end else if (privileged && !model_mode) begin
      model_reg[addr] = data;
    end
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    if (addr == `FW_ADDR_GPIO) begin
      return {28'h0, model_gpio_out, model_gpio_in};
    end
    if (addr == `FW_ADDR_SYSTEM_MODE) begin
      return {32{model_mode}};
    end
    return model_reg[addr];
  endfunction

  // ---------------------------------------------------------------------------
  // Bus and CPU drivers, inputs change 2 ns after the rising edge
  // ---------------------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    bus_req = '0;
    cpu     = '0;
    wait_cycles(RESET_CYCLES);
    reset_n = 1'b1;
    reset_model();
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    bus_req = '{cs: 1'b1, we: 1'b1, address: addr, write_data: data};
    wait_cycles(1);
    bus_req = '0;
    model_write(addr, data);
    check_word("led pins", {29'h0, led_r, led_g, led_b}, model_reg[`FW_ADDR_LED]);
    check_bit("gpio3", gpio3, model_gpio_out[0]);
    check_bit("gpio4", gpio4, model_gpio_out[1]);
  endtask

  // Read data is sampled on the falling edge, mid cycle
  task automatic read_reg(input logic [7:0] addr);
    bus_req = '{cs: 1'b1, we: 1'b0, address: addr, write_data: 32'h0};
    @(negedge clk);
    check_rsp($sformatf("bus_rsp @%02h", addr), bus_rsp,
              '{read_data: expected_read(addr), ready: 1'b1});
    wait_cycles(1);
    bus_req = '0;
  endtask

  task automatic cpu_access(input logic valid, input logic instr, input logic [31:0] addr);
    logic fetch;
    logic out_of_range;
    logic fw_ram;
    logic in_window;
    cpu = '{valid: valid, instr: instr, addr: addr};
    wait_cycles(1);
    cpu = '0;
    fetch        = valid && instr;
    out_of_range = (addr[31:30] == 2'b01) && (addr[29:17] != 13'h0);
    fw_ram       = (addr >= `FW_RAM_FIRST) && (addr <= `FW_RAM_LAST);
    in_window    = model_mon_en && (addr >= model_mon_first) && (addr <= model_mon_last);
    if (fetch && (addr > `FW_ROM_LAST)) begin
      model_mode = 1'b1;
    end else if (fetch && (addr == model_reg[`FW_ADDR_SYSCALL])) begin
      model_mode = 1'b0;
    end
    if ((valid && out_of_range) || (fetch && (fw_ram || in_window))) begin
      model_trap = 1'b1;
    end
    check_bit("system_mode", system_mode, model_mode);
    check_bit("force_trap", force_trap, model_trap);
  endtask

  task automatic report_test(input string name, input int base);
    tests_run++;
    $display("%-24s %s, %0d errors", name, (errors == base) ? "ok" : "FAILED", errors - base);
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  task automatic after_reset_reads();
    int base;
    base = errors;
    apply_reset();
    // Covers identity words, reset values and unmapped zeros
    for (int a = 0; a < 48; a++) begin
      read_reg(8'(a));
    end
    check_bit("led_r", led_r, 1'b1);
    check_bit("led_g", led_g, 1'b1);
    check_bit("led_b", led_b, 1'b0);
    check_bit("gpio3", gpio3, 1'b0);
    check_bit("gpio4", gpio4, 1'b0);
    check_bit("system_mode", system_mode, 1'b0);
    check_bit("force_trap", force_trap, 1'b0);
    check_bit("system_reset", system_reset, 1'b0);
    report_test("after reset", base);
  endtask

  function automatic logic [7:0] pick_addr(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return `FW_ADDR_APP_START;
      3'd1:    return `FW_ADDR_APP_SIZE;
      3'd2:    return `FW_ADDR_SYSCALL;
      3'd3:    return `FW_ADDR_LED;
      3'd4:    return `FW_ADDR_GPIO;
      default: return `FW_ADDR_CDI_FIRST + {5'h0, r[5:3]};
    endcase
  endfunction

  task automatic random_register_traffic();
    int          base;
    logic [31:0] r;
    logic [31:0] data;
    logic [7:0]  addr;
    base = errors;
    apply_reset();
    // Syscall entry in ROM from the start
    write_reg(`FW_ADDR_SYSCALL, random_word() & 32'h0000_1ffc);
    for (int n = 0; n < RAND_OPS; n++) begin
      r    = random_word();
      addr = pick_addr(r);
      if (r[31:29] < 3'd4) begin
        data = random_word();
        // Syscall values stay in ROM so that a later call clears the mode
        if (addr == `FW_ADDR_SYSCALL) begin
          data = data & 32'h0000_1ffc;
        end
        write_reg(addr, data);
      end else if (r[31:29] < 3'd6) begin
        read_reg(addr);
      end else if (r[31:29] == 3'd6) begin
        cpu_access(1'b1, 1'b1, 32'h4000_0000 | (r & 32'h0001_fffc));
      end else begin
        cpu_access(1'b1, 1'b1, model_reg[`FW_ADDR_SYSCALL]);
      end
    end
    report_test("random registers", base);
  endtask

  task automatic gpio_input_sync();
    int          base;
    logic [31:0] r;
    base = errors;
    apply_reset();
    for (int n = 0; n < GPIO_ROUNDS; n++) begin
      r = random_word();
      gpio1 = r[0];
      gpio2 = r[1];
      model_gpio_in = r[1:0];
      wait_cycles(3);
      read_reg(`FW_ADDR_GPIO);
    end
    report_test("gpio inputs", base);
  endtask

  task automatic mode_transitions();
    int base;
    base = errors;
    apply_reset();
    write_reg(`FW_ADDR_SYSCALL, 32'h0000_0100);
    cpu_access(1'b1, 1'b0, 32'h4000_0040);
    cpu_access(1'b0, 1'b1, 32'h4000_0040);
    check_bit("system_mode", system_mode, 1'b0);
    cpu_access(1'b1, 1'b1, 32'h4000_0040);
    check_bit("system_mode", system_mode, 1'b1);
    read_reg(`FW_ADDR_SYSTEM_MODE);
    // Blocked while in system mode
    write_reg(`FW_ADDR_SYSCALL, 32'h0000_0200);
    read_reg(`FW_ADDR_SYSCALL);
    cpu_access(1'b1, 1'b0, 32'h0000_0100);
    cpu_access(1'b0, 1'b1, 32'h0000_0100);
    check_bit("system_mode", system_mode, 1'b1);
    cpu_access(1'b1, 1'b1, 32'h0000_0100);
    check_bit("system_mode", system_mode, 1'b0);
    read_reg(`FW_ADDR_SYSTEM_MODE);
    report_test("mode transitions", base);
  endtask

  task automatic monitor_traps();
    int          base;
    logic [31:0] first;
    logic [31:0] last;
    logic [31:0] r;
    base = errors;
    apply_reset();
    first = 32'h4000_0000 | (random_word() & 32'h0000_7ff0);
    last  = first + 32'h100;
    write_reg(`FW_ADDR_MON_FIRST, first);
    write_reg(`FW_ADDR_MON_LAST, last);
    write_reg(`FW_ADDR_MON_CTRL, 32'h1);
    // Window is locked now
    write_reg(`FW_ADDR_MON_FIRST, first + 32'h1_0000);
    write_reg(`FW_ADDR_MON_LAST, last + 32'h1_0000);
    cpu_access(1'b1, 1'b1, first + 32'h1_0080);
    cpu_access(1'b1, 1'b1, last + 32'h4);
    check_bit("force_trap", force_trap, 1'b0);
    cpu_access(1'b1, 1'b1, last);
    check_bit("force_trap", force_trap, 1'b1);

    apply_reset();
    r = `FW_RAM_FIRST + (random_word() & 32'h0000_07fc);
    cpu_access(1'b1, 1'b0, r);
    cpu_access(1'b1, 1'b1, r);
    check_bit("force_trap", force_trap, 1'b1);

    apply_reset();
    r = 32'h4002_0000 | (random_word() & 32'h3ffe_fffc);
    cpu_access(1'b0, 1'b0, r);
    cpu_access(1'b1, 1'b0, r);
    check_bit("force_trap", force_trap, 1'b1);

    // ROM fetches, RAM fetches and data accesses outside the RAM hole
    apply_reset();
    for (int n = 0; n < LEGAL_ROUNDS; n++) begin
      r = random_word();
      case (r[1:0])
        2'd0:    cpu_access(1'b1, 1'b1, r & 32'h0000_1ffc);
        2'd1:    cpu_access(1'b1, 1'b1, 32'h4000_0000 | (r & 32'h0001_fffc));
        2'd2:    cpu_access(1'b1, 1'b0, `FW_RAM_FIRST + (r & 32'h0000_07fc));
        default: cpu_access(1'b1, 1'b0, {1'b1, r[30:0]});
      endcase
    end
    check_bit("force_trap", force_trap, 1'b0);
    report_test("execution monitor", base);
  endtask

  task automatic reset_strobe();
    int base;
    base = errors;
    apply_reset();
    for (int n = 0; n < 2; n++) begin
      check_bit("system_reset", system_reset, 1'b0);
      write_reg(`FW_ADDR_SYSTEM_RESET, random_word());
      check_bit("system_reset", system_reset, 1'b1);
      wait_cycles(1);
      check_bit("system_reset", system_reset, 1'b0);
    end
    report_test("system reset strobe", base);
  endtask

  initial begin
    rng_state     = SEED;
    checks        = 0;
    errors        = 0;
    tests_run     = 0;
    reset_n       = 1'b0;
    bus_req       = '0;
    cpu           = '0;
    gpio1         = 1'b0;
    gpio2         = 1'b0;
    model_gpio_in = 2'b00;

    after_reset_reads();
    random_register_traffic();
    gpio_input_sync();
    mode_transitions();
    monitor_traps();
    reset_strobe();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/fw_ctrl_pkg.sv
hw/mode_ctrl.sv
hw/exec_monitor.sv
hw/ctrl_regs.sv
hw/fw_ctrl_top.sv
dv/fw_ctrl_chk.sv
dv/fw_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the firmware control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fw_ctrl_tb -f compile.f -o fw_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/fw_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
